/* bitStreamIf.sv */
`timescale 1ns/1ps

// Unstuffed bit stream from the serializer to the stuffer
interface bitStreamIf;

  logic valid;
  logic dataBit;
  // Final bit of the packet's last field
  logic last;
  // Low for the cycle in which a stuff bit goes out
  logic ready;

  modport source (
    output valid,
    output dataBit,
    output last,
    input  ready
  );

  modport sink (
    input  valid,
    input  dataBit,
    input  last,
    output ready
  );

endinterface : bitStreamIf

/* bitStuffer.sv */
`timescale 1ns/1ps

module bitStuffer
  import usbTxPkg::*;
(
  input  logic     clock,
  input  logic     reset_n,
  bitStreamIf.sink stream,
  output logic     lineValid,
  output logic     lineBit,
  output logic     lineLast
);

  localparam int countWidth = $clog2(stuffRunLength + 1);

  logic [countWidth-1:0] onesCount;
  logic stuffNow;
  logic runComplete;
  logic lastPending;

  // A full run of ones means this cycle carries the stuff zero
  assign stuffNow = (onesCount == countWidth'(stuffRunLength));
  assign stream.ready = !stuffNow;

  // Incoming one that completes the run
  assign runComplete = stream.dataBit &&
                       (onesCount == countWidth'(stuffRunLength - 1));

  always_ff @(posedge clock) begin
    if (!reset_n) begin
      lineValid <= 1'b0;
      lineLast <= 1'b0;
      lastPending <= 1'b0;
      onesCount <= '0;
    end else if (stuffNow) begin
      lineValid <= 1'b1;
      lineLast <= lastPending;
      lastPending <= 1'b0;
      onesCount <= '0;
    end else if (stream.valid) begin
      lineValid <= 1'b1;
      // Last bit waits behind a trailing stuff zero
      lineLast <= stream.last && !runComplete;
      lastPending <= stream.last && runComplete;
      if (stream.last && !runComplete)
        onesCount <= '0;
      else if (stream.dataBit)
        onesCount <= onesCount + 1'b1;
      else
        onesCount <= '0;
    end else begin
      lineValid <= 1'b0;
      lineLast <= 1'b0;
    end
  end

  always_ff @(posedge clock) begin
    if (stuffNow)
      lineBit <= 1'b0;
    else if (stream.valid)
      lineBit <= stream.dataBit;
  end

endmodule : bitStuffer

/* crcGenerator.sv */
`timescale 1ns/1ps

// Serial CRC seeded with all ones
// once the data is in, the inverted residue leaves MSB first
module crcGenerator
  import usbTxPkg::*;
#(
  parameter int               width = crc16Width,
  parameter logic [width-1:0] poly  = crc16Poly
) (
  input  logic clock,
  input  logic reset_n,
  input  logic clear,
  input  logic feed,
  input  logic dataBit,
  input  logic shiftOut,
  output logic residueBit
);

  logic [width-1:0] crcReg;
  logic feedback;

  assign feedback = crcReg[width-1] ^ dataBit;

  // USB sends the complement of the remainder
  assign residueBit = ~crcReg[width-1];

  always_ff @(posedge clock) begin
    if (!reset_n) begin
      crcReg <= '1;
    end else if (clear) begin
      crcReg <= '1;
    end else if (feed) begin
      crcReg <= {crcReg[width-2:0], 1'b0} ^ (feedback ? poly : '0);
    end else if (shiftOut) begin
      // Walk the residue toward the MSB
      crcReg <= {crcReg[width-2:0], 1'b1};
    end
  end

endmodule : crcGenerator

/* flist.f */
usbTxPkg.sv
bitStreamIf.sv
crcGenerator.sv
packetSerializer.sv
bitStuffer.sv
lineDriver.sv
usbHostTx.sv
usbHostTx_sva.sv
usbTxMonitor.sv
usbHostTxTb.sv

/* lineDriver.sv */
`timescale 1ns/1ps

module lineDriver
  import usbTxPkg::*;
(
  input  logic clock,
  input  logic reset_n,
  input  logic lineValid,
  input  logic lineBit,
  input  logic lineLast,
  output logic dp,
  output logic dm,
  output logic busActive,
  output logic packetDone
);

  localparam int se0CountWidth = $clog2(eopSe0Cycles + 1);

  typedef enum logic [2:0] {dIdle, dData, dSe0A, dSe0B, dJEnd} stateType;

  stateType state;
  logic level;
  logic baseLevel;
  logic nextLevel;
  logic endPending;
  logic [se0CountWidth-1:0] se0Count;

  // Level is 1 for J; each packet starts from J
  assign baseLevel = (state == dIdle) ? 1'b1 : level;
  // NRZI toggles on a zero and holds on a one
  assign nextLevel = lineBit ? baseLevel : ~baseLevel;

  always_ff @(posedge clock) begin
    if (!reset_n) begin
      state <= dIdle;
      level <= 1'b1;
      endPending <= 1'b0;
      se0Count <= '0;
    end else begin
      case (state)
        dIdle: begin
          if (lineValid) begin
            state <= dData;
            level <= nextLevel;
            endPending <= lineLast;
          end
        end
        dData: begin
          if (endPending) begin
            state <= dSe0A;
            endPending <= 1'b0;
            se0Count <= se0CountWidth'(1);
          end else if (lineValid) begin
            level <= nextLevel;
            endPending <= lineLast;
          end
        end
        dSe0A: begin
          state <= dSe0B;
          se0Count <= se0Count + 1'b1;
        end
        dSe0B: begin
          if (se0Count == se0CountWidth'(eopSe0Cycles))
            state <= dJEnd;
          else
            se0Count <= se0Count + 1'b1;
        end
        default: state <= dIdle;
      endcase
    end
  end

  always_comb begin
    case (state)
      dData: begin
        dp = level;
        dm = ~level;
      end
      dSe0A, dSe0B: begin
        dp = 1'b0;
        dm = 1'b0;
      end
      // Idle and end of packet both sit at J
      default: begin
        dp = 1'b1;
        dm = 1'b0;
      end
    endcase
  end

  assign busActive = (state != dIdle);
  assign packetDone = (state == dJEnd);

endmodule : lineDriver

/* packetSerializer.sv */
`timescale 1ns/1ps

module packetSerializer
  import usbTxPkg::*;
#(
  parameter logic [crc5Width-1:0]  crc5Poly  = usbTxPkg::crc5Poly,
  parameter logic [crc16Width-1:0] crc16Poly = usbTxPkg::crc16Poly
) (
  input  logic                    clock,
  input  logic                    reset_n,
  input  logic                    start,
  input  pidType                  pid,
  input  logic [addrWidth-1:0]    addr,
  input  logic [endpWidth-1:0]    endp,
  input  logic [payloadWidth-1:0] payload,
  bitStreamIf.source              stream
);

  localparam int countWidth = $clog2(payloadWidth + 1);
  localparam int syncWidth = $bits(syncPattern);

  typedef enum logic [2:0] {
    sIdle, sSync, sPid, sAddr, sEndp, sPayload, sCrc5, sCrc16
  } stateType;

  stateType state;
  stateType nextState;
  logic [payloadWidth-1:0] shiftReg;
  logic [payloadWidth-1:0] loadField;
  logic [countWidth-1:0] bitsLeft;
  logic [countWidth-1:0] loadCount;
  logic load;
  logic [syncWidth-1:0] syncLsbFirst;
  logic [pidWidth-1:0] pidBits;
  logic accept;
  logic fieldDone;
  logic handshake;
  logic crc5Feed;
  logic crc5Shift;
  logic crc5Bit;
  logic crc16Feed;
  logic crc16Shift;
  logic crc16Bit;

  // SYNC goes out MSB first, so flip it and shift everything right
  assign syncLsbFirst = {<<{syncPattern}};
  assign pidBits = pid;
  assign accept = stream.valid && stream.ready;
  assign fieldDone = (bitsLeft == countWidth'(1));
  assign handshake = !(pid inside {pidOut, pidIn, pidData0});

  assign crc5Feed = accept && ((state == sAddr) || (state == sEndp));
  assign crc5Shift = accept && (state == sCrc5);
  assign crc16Feed = accept && (state == sPayload);
  assign crc16Shift = accept && (state == sCrc16);

  assign stream.valid = (state != sIdle);
  assign stream.last = fieldDone &&
                       ((state == sCrc5) || (state == sCrc16) ||
                        ((state == sPid) && handshake));

  always_comb begin
    case (state)
      sCrc5:   stream.dataBit = crc5Bit;
      sCrc16:  stream.dataBit = crc16Bit;
      default: stream.dataBit = shiftReg[0];
    endcase
  end

  // Picks the next field once the current one has gone out
  always_comb begin
    nextState = state;
    load = 1'b0;
    loadField = '0;
    loadCount = '0;
    case (state)
      sIdle: begin
        if (start) begin
          nextState = sSync;
          load = 1'b1;
          loadField[syncWidth-1:0] = syncLsbFirst;
          loadCount = countWidth'(syncWidth);
        end
      end
      sSync: begin
        if (accept && fieldDone) begin
          nextState = sPid;
          load = 1'b1;
          loadField[2*pidWidth-1:0] = {~pidBits, pidBits};
          loadCount = countWidth'(2 * pidWidth);
        end
      end
      sPid: begin
        if (accept && fieldDone) begin
          load = !handshake;
          case (pid)
            pidOut, pidIn: begin
              nextState = sAddr;
              loadField[addrWidth-1:0] = addr;
              loadCount = countWidth'(addrWidth);
            end
            pidData0: begin
              nextState = sPayload;
              loadField = payload;
              loadCount = countWidth'(payloadWidth);
            end
            // Handshakes end right after the PID
            default: nextState = sIdle;
          endcase
        end
      end
      sAddr: begin
        if (accept && fieldDone) begin
          nextState = sEndp;
          load = 1'b1;
          loadField[endpWidth-1:0] = endp;
          loadCount = countWidth'(endpWidth);
        end
      end
      sEndp: begin
        if (accept && fieldDone) begin
          nextState = sCrc5;
          load = 1'b1;
          loadCount = countWidth'(crc5Width);
        end
      end
      sPayload: begin
        if (accept && fieldDone) begin
          nextState = sCrc16;
          load = 1'b1;
          loadCount = countWidth'(crc16Width);
        end
      end
      default: begin
        if (accept && fieldDone)
          nextState = sIdle;
      end
    endcase
  end

  always_ff @(posedge clock) begin
    if (!reset_n) begin
      state <= sIdle;
      bitsLeft <= '0;
    end else begin
      state <= nextState;
      if (load)
        bitsLeft <= loadCount;
      else if (accept)
        bitsLeft <= bitsLeft - 1'b1;
    end
  end

  always_ff @(posedge clock) begin
    if (load)
      shiftReg <= loadField;
    else if (accept)
      shiftReg <= shiftReg >> 1;
  end

  crcGenerator #(.width(crc5Width), .poly(crc5Poly)) crc5 (
    .clock,
    .reset_n,
    .clear      (start),
    .feed       (crc5Feed),
    .dataBit    (shiftReg[0]),
    .shiftOut   (crc5Shift),
    .residueBit (crc5Bit)
  );

  crcGenerator #(.width(crc16Width), .poly(crc16Poly)) crc16 (
    .clock,
    .reset_n,
    .clear      (start),
    .feed       (crc16Feed),
    .dataBit    (shiftReg[0]),
    .shiftOut   (crc16Shift),
    .residueBit (crc16Bit)
  );

endmodule : packetSerializer

/* usbHostTx.sv */
`timescale 1ns/1ps

module usbHostTx
  import usbTxPkg::*;
#(
  parameter logic [crc5Width-1:0]  crc5Poly  = usbTxPkg::crc5Poly,
  parameter logic [crc16Width-1:0] crc16Poly = usbTxPkg::crc16Poly
) (
  input  logic                    clock,
  input  logic                    reset_n,
  input  logic                    req,
  input  pidType                  pid,
  input  logic [addrWidth-1:0]    addr,
  input  logic [endpWidth-1:0]    endp,
  input  logic [payloadWidth-1:0] payload,
  output logic                    ack,
  output logic                    dp,
  output logic                    dm,
  output logic                    busActive
);

  typedef enum logic [1:0] {rIdle, rSending, rAcked} reqStateType;

  reqStateType reqState;
  pidType pidReg;
  logic [addrWidth-1:0] addrReg;
  logic [endpWidth-1:0] endpReg;
  logic [payloadWidth-1:0] payloadReg;
  logic start;
  logic lineValid;
  logic lineBit;
  logic lineLast;
  logic packetDone;

  bitStreamIf stream ();

  // req can only be high in idle once the previous ack has dropped
  assign start = (reqState == rIdle) && req;
  assign ack = (reqState == rAcked);

  always_ff @(posedge clock) begin
    if (start) begin
      pidReg <= pid;
      addrReg <= addr;
      endpReg <= endp;
      payloadReg <= payload;
    end
  end

  always_ff @(posedge clock) begin
    if (!reset_n) begin
      reqState <= rIdle;
    end else begin
      case (reqState)
        rIdle:    if (req) reqState <= rSending;
        rSending: if (packetDone) reqState <= rAcked;
        rAcked:   if (!req) reqState <= rIdle;
        default:  reqState <= rIdle;
      endcase
    end
  end

  packetSerializer #(.crc5Poly(crc5Poly), .crc16Poly(crc16Poly)) serializer (
    .clock,
    .reset_n,
    .start,
    .pid     (pidReg),
    .addr    (addrReg),
    .endp    (endpReg),
    .payload (payloadReg),
    .stream  (stream.source)
  );

  bitStuffer stuffer (
    .clock,
    .reset_n,
    .stream (stream.sink),
    .lineValid,
    .lineBit,
    .lineLast
  );

  lineDriver driver (
    .clock,
    .reset_n,
    .lineValid,
    .lineBit,
    .lineLast,
    .dp,
    .dm,
    .busActive,
    .packetDone
  );

endmodule : usbHostTx

/* usbHostTxTb.sv */
`timescale 1ns/1ps

module usbHostTxTb
  import usbTxPkg::*;
();

  localparam int numRows = 10;
  localparam int periodNs = 20;
  localparam int resetCycles = 5;
  localparam int cyclesPerRow = 200;

  typedef enum logic [1:0] {payZero, payOnes, payRandom} payloadSelType;

  typedef struct packed {
    pidType pid;
    logic randomFields;
    logic [addrWidth-1:0] addr;
    logic [endpWidth-1:0] endp;
    payloadSelType payloadSel;
    // Expected stuff bits or -1 where random data makes it vary
    int stuffCount;
  } rowType;

  logic clock;
  logic reset_n;
  logic req;
  pidType pid;
  logic [addrWidth-1:0] addr;
  logic [endpWidth-1:0] endp;
  logic [payloadWidth-1:0] payload;
  logic ack;
  logic dp;
  logic dm;
  logic busActive;
  logic [31:0] lfsrState;
  rowType rows [numRows];

  always #(periodNs / 2) clock = ~clock;

  usbHostTx #(.crc5Poly(crc5Poly), .crc16Poly(crc16Poly)) dut (
    .clock,
    .reset_n,
    .req,
    .pid,
    .addr,
    .endp,
    .payload,
    .ack,
    .dp,
    .dm,
    .busActive
  );

  usbTxMonitor monitor (
    .clock,
    .reset_n,
    .req,
    .ack,
    .dp,
    .dm,
    .busActive
  );

  task automatic fillTable();
    rows[0] = '{pidOut, 1'b1, 7'h00, 4'h0, payZero, -1};
    rows[1] = '{pidIn, 1'b1, 7'h00, 4'h0, payZero, -1};
    rows[2] = '{pidData0, 1'b0, 7'h00, 4'h0, payRandom, -1};
    // Runs of six ones through the payload and into the CRC16
    rows[3] = '{pidData0, 1'b0, 7'h00, 4'h0, payOnes, 12};
    rows[4] = '{pidAck, 1'b0, 7'h00, 4'h0, payZero, 0};
    rows[5] = '{pidNak, 1'b0, 7'h00, 4'h0, payZero, 0};
    rows[6] = '{pidOut, 1'b0, 7'h7f, 4'hf, payZero, 2};
    rows[7] = '{pidData0, 1'b0, 7'h00, 4'h0, payRandom, -1};
    rows[8] = '{pidIn, 1'b1, 7'h00, 4'h0, payZero, -1};
    rows[9] = '{pidData0, 1'b0, 7'h00, 4'h0, payZero, -1};
  endtask

  // Galois LFSR shifting right
  function automatic logic [31:0] lfsrNext(input logic [31:0] state);
    return state[0] ? ((state >> 1) ^ 32'h8020_0003) : (state >> 1);
  endfunction

  task automatic randomBits(input int count, output logic [payloadWidth-1:0] value);
    value = '0;
    for (int i = 0; i < count; i++) begin
      lfsrState = lfsrNext(lfsrState);
      value[i] = lfsrState[0];
    end
  endtask

  task automatic sendRow(input rowType row);
    logic [payloadWidth-1:0] bits;
    @(posedge clock);
    #2;
    pid = row.pid;
    addr = row.addr;
    endp = row.endp;
    if (row.randomFields) begin
      randomBits(addrWidth, bits);
      addr = bits[addrWidth-1:0];
      randomBits(endpWidth, bits);
      endp = bits[endpWidth-1:0];
    end
    case (row.payloadSel)
      payOnes:   payload = '1;
      payRandom: randomBits(payloadWidth, payload);
      default:   payload = '0;
    endcase
    monitor.expectPacket(pid, addr, endp, payload, row.stuffCount);
    req = 1'b1;
    // Fields stay put until ack
    do @(negedge clock); while (!ack);
    @(posedge clock);
    #2;
    req = 1'b0;
    do @(negedge clock); while (ack);
  endtask

  initial begin
    clock = 1'b0;
    reset_n = 1'b0;
    req = 1'b0;
    pid = pidAck;
    addr = '0;
    endp = '0;
    payload = '0;
    lfsrState = 32'h7b98_0026;
    fillTable();
    repeat (resetCycles) @(posedge clock);
    #2;
    reset_n = 1'b1;
    for (int i = 0; i < numRows; i++)
      sendRow(rows[i]);
    repeat (4) @(posedge clock);
    $display("Tests seen: %0d of %0d, errors: %0d, assertion failures: %0d",
             monitor.testCount, numRows, monitor.errorCount, dut.assertions.failCount);
    if (monitor.testCount != numRows)
      $display("Only %0d of %0d packets were seen on the bus", monitor.testCount, numRows);
    if (monitor.errorCount == 0 && monitor.testCount == numRows &&
        dut.assertions.failCount == 0) begin
      $display("*** TEST PASSED ***");
    end else begin
      $display("*** TEST FAILED ***");
    end
    $finish;
  end

  // Watchdog
  initial begin
    #((numRows * cyclesPerRow + resetCycles) * periodNs);
    $display("Timeout: the run did not finish within %0d clock cycles",
             numRows * cyclesPerRow + resetCycles);
    $display("*** TEST FAILED ***");
    $finish;
  end

endmodule : usbHostTxTb

/* usbHostTx_sva.sv */
`timescale 1ns/1ps

module usbHostTx_sva
  import usbTxPkg::*;
(
  input logic clock,
  input logic reset_n,
  input logic req,
  input logic ack,
  input logic dp,
  input logic dm,
  input logic busActive
);

  logic se0;
  int failCount = 0;

  assign se0 = !dp && !dm;

  ackRisesWithReq: assert property (
    @(posedge clock) disable iff (!reset_n) $rose(ack) |-> req
  ) else begin
    failCount++;
    $error("ack rose while req was low");
  end

  // ack may only drop once req has gone low
  ackFallsAfterReq: assert property (
    @(posedge clock) disable iff (!reset_n) $fell(ack) |-> !$past(req)
  ) else begin
    failCount++;
    $error("ack fell while req was still high");
  end

  // Between packets the line is released and parked at J
  idleIsJ: assert property (
    @(posedge clock) disable iff (!reset_n) (!req || ack) |-> (!busActive && dp && !dm)
  ) else begin
    failCount++;
    $error("bus is not idle at J between packets");
  end

  se0Length: assert property (
    @(posedge clock) disable iff (!reset_n) $rose(se0) |-> se0 [*eopSe0Cycles] ##1 !se0
  ) else begin
    failCount++;
    $error("SE0 at end of packet has the wrong length");
  end

endmodule : usbHostTx_sva

bind usbHostTx usbHostTx_sva assertions (
  .clock,
  .reset_n,
  .req,
  .ack,
  .dp,
  .dm,
  .busActive
);

/* usbTxMonitor.sv */
`timescale 1ns/1ps

module usbTxMonitor
  import usbTxPkg::*;
(
  input logic clock,
  input logic reset_n,
  input logic req,
  input logic ack,
  input logic dp,
  input logic dm,
  input logic busActive
);

  localparam int maxBits = 160;

  int errorCount;
  int testCount;
  pidType pidQ [$];
  logic [addrWidth-1:0] addrQ [$];
  logic [endpWidth-1:0] endpQ [$];
  logic [payloadWidth-1:0] payloadQ [$];
  int stuffQ [$];
  logic rawBits [maxBits];
  logic expBits [maxBits];
  int rawCount;
  int expCount;
  int se0Seen;
  logic lineLevel;
  logic prevAck;
  logic resetDone;

  initial begin
    errorCount = 0;
    testCount = 0;
    rawCount = 0;
    se0Seen = 0;
    lineLevel = 1'b1;
    prevAck = 1'b0;
    resetDone = 1'b0;
  end

  task automatic expectPacket(input pidType pid, input logic [addrWidth-1:0] addr,
                              input logic [endpWidth-1:0] endp,
                              input logic [payloadWidth-1:0] payload, input int stuffCount);
    pidQ.push_back(pid);
    addrQ.push_back(addr);
    endpQ.push_back(endp);
    payloadQ.push_back(payload);
    stuffQ.push_back(stuffCount);
  endtask

  function automatic string pidName(input pidType pid);
    case (pid)
      pidOut:   return "OUT";
      pidIn:    return "IN";
      pidData0: return "DATA0";
      pidAck:   return "ACK";
      pidNak:   return "NAK";
      default:  return "unknown PID";
    endcase
  endfunction

  // USB CRC over LSB-first data seeded with ones and returned inverted
  function automatic logic [15:0] usbCrc(input logic [payloadWidth-1:0] data, input int count,
                                         input int width, input logic [15:0] poly);
    logic [15:0] mask;
    logic [15:0] crc;
    logic feedback;
    mask = (16'h1 << width) - 16'h1;
    crc = mask;
    for (int i = 0; i < count; i++) begin
      feedback = crc[width-1] ^ data[i];
      crc = ((crc << 1) & mask) ^ (feedback ? poly : 16'h0);
    end
    return ~crc & mask;
  endfunction

  task automatic appendBits(input logic [payloadWidth-1:0] value, input int count,
                            input bit msbFirst);
    for (int i = 0; i < count; i++) begin
      expBits[expCount] = msbFirst ? value[count-1-i] : value[i];
      expCount++;
    end
  endtask

  task automatic buildExpected(input pidType pid, input logic [addrWidth-1:0] addr,
                               input logic [endpWidth-1:0] endp,
                               input logic [payloadWidth-1:0] payload);
    expCount = 0;
    appendBits(syncPattern, 8, 1'b1);
    // PID nibble first, then its complement
    appendBits({~pid, pid}, 8, 1'b0);
    case (pid)
      pidOut, pidIn: begin
        appendBits(addr, addrWidth, 1'b0);
        appendBits(endp, endpWidth, 1'b0);
        appendBits(usbCrc({endp, addr}, addrWidth + endpWidth, crc5Width, crc5Poly),
                   crc5Width, 1'b1);
      end
      pidData0: begin
        appendBits(payload, payloadWidth, 1'b0);
        appendBits(usbCrc(payload, payloadWidth, crc16Width, crc16Poly), crc16Width, 1'b1);
      end
      default: ;
    endcase
  endtask

  task automatic checkPacket();
    pidType pid;
    logic gotBits [maxBits];
    int gotCount;
    int ones;
    int stuffCount;
    int expStuff;
    int firstBad;
    int errorsBefore;
    if (pidQ.size() == 0) begin
      $display("Error at %0d ns: packet on the line with no request outstanding", $time);
      errorCount++;
      return;
    end
    errorsBefore = errorCount;
    pid = pidQ.pop_front();
    buildExpected(pid, addrQ.pop_front(), endpQ.pop_front(), payloadQ.pop_front());
    expStuff = stuffQ.pop_front();
    gotCount = 0;
    ones = 0;
    stuffCount = 0;
    // Strip the zero that follows every run of six ones
    for (int i = 0; i < rawCount && i < maxBits; i++) begin
      if (ones == stuffRunLength) begin
        if (rawBits[i]) begin
          $display("Error at %0d ns: missing stuff zero at line bit %0d", $time, i);
          errorCount++;
        end
        stuffCount++;
        ones = 0;
      end else begin
        gotBits[gotCount] = rawBits[i];
        gotCount++;
        ones = rawBits[i] ? ones + 1 : 0;
      end
    end
    if (ones == stuffRunLength) begin
      $display("Error at %0d ns: missing stuff zero before EOP", $time);
      errorCount++;
    end
    firstBad = -1;
    if (gotCount != expCount) begin
      $display("Error at %0d ns: decoded %0d bits, expected %0d", $time, gotCount, expCount);
      errorCount++;
    end else begin
      for (int i = 0; i < expCount && firstBad < 0; i++)
        if (gotBits[i] !== expBits[i])
          firstBad = i;
    end
    if (firstBad >= 0) begin
      $display("Error at %0d ns: bit %0d is %b, expected %b", $time, firstBad,
               gotBits[firstBad], expBits[firstBad]);
      errorCount++;
    end
    if (expStuff >= 0 && stuffCount != expStuff) begin
      $display("Error at %0d ns: %0d stuff bits, expected %0d", $time, stuffCount, expStuff);
      errorCount++;
    end
    testCount++;
    $display("Test %0d %s: %0d bits, %0d stuff bits, %s", testCount, pidName(pid), gotCount,
             stuffCount, (errorCount == errorsBefore) ? "ok" : "mismatch");
  endtask

  // Line outputs settle after the rising edge, so look at the falling edge
  always @(negedge clock) begin
    if (reset_n) begin
      if (!resetDone && ack) begin
        $display("Error at %0d ns: ack is high after reset", $time);
        errorCount++;
      end
      resetDone = 1'b1;
      if (ack && !prevAck && !req) begin
        $display("Error at %0d ns: ack rose while req was low", $time);
        errorCount++;
      end
      if (!ack && prevAck && req) begin
        $display("Error at %0d ns: ack fell while req was still high", $time);
        errorCount++;
      end
      prevAck = ack;
      if (!busActive) begin
        if (!(dp && !dm)) begin
          $display("Error at %0d ns: idle bus is dp=%b dm=%b, expected J", $time, dp, dm);
          errorCount++;
        end
      end else if (dp && dm) begin
        $display("Error at %0d ns: SE1 on the bus", $time);
        errorCount++;
      end else if (!dp && !dm) begin
        se0Seen++;
      end else if (se0Seen > 0) begin
        // J after SE0 closes the packet
        if (se0Seen != eopSe0Cycles) begin
          $display("Error at %0d ns: EOP had %0d SE0 bits", $time, se0Seen);
          errorCount++;
        end
        checkPacket();
        rawCount = 0;
        se0Seen = 0;
        lineLevel = 1'b1;
      end else begin
        // Under NRZI an unchanged level is a one
        if (rawCount < maxBits)
          rawBits[rawCount] = (dp == lineLevel);
        rawCount++;
        lineLevel = dp;
      end
    end
  end

endmodule : usbTxMonitor

/* usbTxPkg.sv */
package usbTxPkg;

  // PID opcodes with their USB codes
  typedef enum logic [3:0] {
    pidOut   = 4'b0001,
    pidIn    = 4'b1001,
    pidData0 = 4'b0011,
    pidAck   = 4'b0010,
    pidNak   = 4'b1010
  } pidType;

  // Packet field widths
  localparam int pidWidth = 4;
  localparam int addrWidth = 7;
  localparam int endpWidth = 4;
  localparam int payloadWidth = 64;

  // Seven zeros then a one, sent MSB first
  localparam logic [7:0] syncPattern = 8'b0000_0001;

  localparam int crc5Width = 5;
  localparam int crc16Width = 16;

  // x^5 + x^2 + 1
  localparam logic [crc5Width-1:0] crc5Poly = 5'b0_0101;

  // x^16 + x^15 + x^2 + 1
  localparam logic [crc16Width-1:0] crc16Poly = 16'h8005;

  // A zero goes in after this many ones in a row
  localparam int stuffRunLength = 6;

  // SE0 bit times at the end of a packet
  localparam int eopSe0Cycles = 2;

endpackage : usbTxPkg
